// ==== verification/rocache_stimulus.txt ====
# op addr_or_generation expected_data expected_memory_transfers (hex hex hex decimal)
# R read, F flush, G new memory generation; data and transfer columns are 0 for F and G
R 1000 10001000 4
R 1008 10081008 0
R 0104 01040104 1
R 0104 01040104 1
G 00ff 00000000 0
R 1004 10041004 0
F 0000 00000000 0
R 1004 10fb1004 4
R 100c 10f3100c 0
R 1020 10df1020 4
R 1120 11df1120 4
R 1020 10df1020 4
R 1120 11df1120 4
R 4010 40ef4010 4
R 4014 40eb4014 0
R 4800 48ff4800 1
R 0ffc 0f030ffc 1
R 1ffc 1f031ffc 4
G 1234 00000000 0
R 1ff0 1f0f1ff0 0
F 0000 00000000 0
R 1ff0 0dc41ff0 4
R 0104 13300104 1
R 47fc 55c847fc 4
R 4000 52344000 4
R 4004 52304004 0

// ==== rocache_top.f ====
logic/rocache_cfg_pkg.sv
logic/rocache_types_pkg.sv
logic/rocache_region_decode.sv
logic/rocache_line_store.sv
logic/rocache_refill.sv
logic/rocache_ctrl.sv
logic/rocache_top.sv
verification/tb_clock_gen.sv
verification/tb_rocache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status carries pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f rocache_top.f --top-module tb_rocache -o tb_rocache_sim &&
  ./obj_dir/tb_rocache_sim || exit 1

// ==== verification/tb_rocache.sv ====
// Read-only cache testbench that replays the stimulus file against a backing memory model
`timescale 1ns/1ps
`default_nettype none

module tb_rocache;

  localparam int    CLK_PERIOD_NS   = 40;
  localparam int    RESET_CYCLES    = 2;
  localparam int    CYCLES_PER_LINE = 60;
  localparam int    RNG_SEED        = 35355;
  localparam int    HIT_LATENCY     = 2;
  localparam int    FLUSH_LATENCY   = int'(rocache_cfg_pkg::LINE_COUNT) + 1;
  localparam string STIM_FILE       = "verification/rocache_stimulus.txt";

  logic                                                    clk_i;
  logic                                                    rst_ni;
  logic                                                    rd_req_i;
  rocache_types_pkg::addr_t                                rd_addr_i;
  logic                                                    rd_ack_o;
  rocache_types_pkg::word_t                                rd_data_o;
  logic                                                    flush_req_i;
  logic                                                    flush_ack_o;
  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_start_i;
  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_end_i;
  logic                                                    mem_req_o;
  rocache_types_pkg::addr_t                                mem_addr_o;
  logic                                                    mem_ack_i;
  rocache_types_pkg::word_t                                mem_data_i;

  // One entry per stimulus line
  string                    op_q[$];
  rocache_types_pkg::addr_t arg_q[$];
  rocache_types_pkg::word_t exp_data_q[$];
  int                       exp_xfer_q[$];

  rocache_types_pkg::addr_t generation    = '0;
  rocache_types_pkg::addr_t mem_addr_seen = '0;
  logic                     mem_req_seen  = 1'b0;
  logic                     delay_armed   = 1'b0;
  int                       ack_delay     = 0;
  int                       xfer_count    = 0;
  int                       cycle_count   = 0;
  int                       timeout_limit = 0;

  tb_clock_gen #(
    .PERIOD_NS    ( CLK_PERIOD_NS ),
    .RESET_CYCLES ( RESET_CYCLES  )
  ) u_clock_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  rocache_top u_rocache_top (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .rd_req_i      ( rd_req_i      ),
    .rd_addr_i     ( rd_addr_i     ),
    .rd_ack_o      ( rd_ack_o      ),
    .rd_data_o     ( rd_data_o     ),
    .flush_req_i   ( flush_req_i   ),
    .flush_ack_o   ( flush_ack_o   ),
    .range_start_i ( range_start_i ),
    .range_end_i   ( range_end_i   ),
    .mem_req_o     ( mem_req_o     ),
    .mem_addr_o    ( mem_addr_o    ),
    .mem_ack_i     ( mem_ack_i     ),
    .mem_data_i    ( mem_data_i    )
  );

  task automatic end_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("[ERROR] %s", what);
    end_with_failure();
  endtask

  // Memory word holds address XOR generation in the upper half and the address in the lower
  function automatic rocache_types_pkg::word_t memory_word(input rocache_types_pkg::addr_t addr);
    rocache_types_pkg::addr_t upper;
    upper = addr ^ generation;
    return {upper, addr};
  endfunction

  task automatic load_stimulus();
    int                       fd;
    int                       fields;
    string                    line;
    string                    op;
    rocache_types_pkg::addr_t arg;
    rocache_types_pkg::word_t exp_data;
    int                       exp_xfers;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      report_problem("could not open the stimulus file");
    end
    while ($fgets(line, fd) != 0) begin
      // Comment and blank lines carry no operation
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%s %h %h %d", op, arg, exp_data, exp_xfers);
        if (fields != 4) begin
          report_problem($sformatf("stimulus line is malformed: %s", line));
        end
        op_q.push_back(op);
        arg_q.push_back(arg);
        exp_data_q.push_back(exp_data);
        exp_xfer_q.push_back(exp_xfers);
      end
    end
    $fclose(fd);
  endtask

  // One four-phase transfer on the read or flush port with its data, cost and timing checks
  task automatic run_handshake(input logic is_flush, input rocache_types_pkg::addr_t addr,
                               input rocache_types_pkg::word_t exp_data, input int exp_xfers,
                               input string name);
    int   start_xfers;
    int   edges;
    logic ack;
    @(posedge clk_i);
    if (is_flush) begin
      flush_req_i <= 1'b1;
    end else begin
      rd_req_i  <= 1'b1;
      rd_addr_i <= addr;
    end
    start_xfers = xfer_count;
    edges = 0;
    ack = 1'b0;
    while (!ack) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      ack = is_flush ? flush_ack_o : rd_ack_o;
    end
    // First counted edge is the one that samples the request
    if (is_flush) begin
      assert (edges - 1 == FLUSH_LATENCY)
        else report_mismatch({name, " flush latency"}, FLUSH_LATENCY, edges - 1);
    end else begin
      assert (rd_data_o == exp_data)
        else report_mismatch({name, " data"}, exp_data, rd_data_o);
      if (exp_xfers == 0) begin
        assert (edges - 1 == HIT_LATENCY)
          else report_mismatch({name, " hit latency"}, HIT_LATENCY, edges - 1);
      end
    end
    assert (xfer_count - start_xfers == exp_xfers)
      else report_mismatch({name, " memory transfers"}, exp_xfers, xfer_count - start_xfers);
    @(posedge clk_i);
    if (is_flush) begin
      flush_req_i <= 1'b0;
    end else begin
      rd_req_i <= 1'b0;
    end
    // Ack holds until the cache has sampled the low request
    @(negedge clk_i);
    ack = is_flush ? flush_ack_o : rd_ack_o;
    assert (ack) else report_mismatch({name, " ack held"}, 32'd1, {31'd0, ack});
    @(negedge clk_i);
    ack = is_flush ? flush_ack_o : rd_ack_o;
    assert (!ack) else report_mismatch({name, " ack released"}, 32'd0, {31'd0, ack});
  endtask

  // Memory port outputs are sampled in the low clock phase
  always @(negedge clk_i) begin
    if (mem_req_o === 1'b1 && !mem_req_seen) begin
      xfer_count <= xfer_count + 1;
    end
    mem_req_seen  <= (mem_req_o === 1'b1);
    mem_addr_seen <= mem_addr_o;
  end

  // Backing memory with a random ack delay of 0 to 3 cycles
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_ack_i   <= 1'b0;
      delay_armed = 1'b0;
    end else if (mem_ack_i) begin
      if (!mem_req_seen) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_req_seen) begin
      if (!delay_armed) begin
        ack_delay   = $urandom % 4;
        delay_armed = 1'b1;
      end
      if (ack_delay == 0) begin
        mem_ack_i   <= 1'b1;
        mem_data_i  <= memory_word(mem_addr_seen);
        delay_armed = 1'b0;
      end else begin
        ack_delay = ack_delay - 1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      report_problem($sformatf("the run hung, no end after %0d cycles", cycle_count));
    end
  end

  initial begin
    string name;
    rd_req_i         = 1'b0;
    rd_addr_i        = '0;
    flush_req_i      = 1'b0;
    mem_ack_i        = 1'b0;
    mem_data_i       = '0;
    range_start_i[0] = 16'h1000;
    range_end_i[0]   = 16'h2000;
    range_start_i[1] = 16'h4000;
    range_end_i[1]   = 16'h4800;
    void'($urandom(RNG_SEED));
    load_stimulus();
    timeout_limit = CYCLES_PER_LINE * op_q.size() + RESET_CYCLES;
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    assert (rd_ack_o == 1'b0) else report_mismatch("reset rd_ack_o", 32'd0, {31'd0, rd_ack_o});
    assert (flush_ack_o == 1'b0)
      else report_mismatch("reset flush_ack_o", 32'd0, {31'd0, flush_ack_o});
    assert (mem_req_o == 1'b0) else report_mismatch("reset mem_req_o", 32'd0, {31'd0, mem_req_o});
    for (int i = 0; i < op_q.size(); i++) begin
      name = $sformatf("step %0d %s 0x%h", i, op_q[i], arg_q[i]);
      if (op_q[i] == "R") begin
        run_handshake(1'b0, arg_q[i], exp_data_q[i], exp_xfer_q[i], name);
      end else if (op_q[i] == "F") begin
        run_handshake(1'b1, arg_q[i], exp_data_q[i], exp_xfer_q[i], name);
      end else if (op_q[i] == "G") begin
        // Memory is idle between operations
        generation = arg_q[i];
      end else begin
        report_problem($sformatf("unknown operation %s in the stimulus file", op_q[i]));
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset generator with a free-running clock and an active-low reset pulse
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Reset spans whole cycles and is released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/rocache_top.sv ====
// Read-only constant cache top level wiring the decoder, controller, stores and refill unit
`timescale 1ns/1ps
`default_nettype none

module rocache_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    rd_req_i,
  input  rocache_types_pkg::addr_t                                rd_addr_i,
  output logic                                                    rd_ack_o,
  output rocache_types_pkg::word_t                                rd_data_o,
  input  logic                                                    flush_req_i,
  output logic                                                    flush_ack_o,
  input  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_start_i,
  input  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_end_i,
  output logic                                                    mem_req_o,
  output rocache_types_pkg::addr_t                                mem_addr_o,
  input  logic                                                    mem_ack_i,
  input  rocache_types_pkg::word_t                                mem_data_i
);

  logic                          cacheable;
  rocache_types_pkg::index_t     store_rd_index;
  rocache_types_pkg::tag_entry_t tag_rd;
  rocache_types_pkg::line_t      line_rd;
  logic                          store_wr_en;
  rocache_types_pkg::index_t     store_wr_index;
  rocache_types_pkg::tag_entry_t tag_wr;
  rocache_types_pkg::line_t      line_wr;
  logic                          refill_start;
  rocache_types_pkg::addr_t      refill_addr;
  logic                          refill_full_line;
  logic                          refill_done;
  rocache_types_pkg::line_t      refill_line;

  rocache_region_decode u_region_decode (
    .addr_i        ( rd_addr_i     ),
    .range_start_i ( range_start_i ),
    .range_end_i   ( range_end_i   ),
    .cacheable_o   ( cacheable     )
  );

  rocache_ctrl u_ctrl (
    .clk_i              ( clk_i            ),
    .rst_ni             ( rst_ni           ),
    .rd_req_i           ( rd_req_i         ),
    .rd_addr_i          ( rd_addr_i        ),
    .rd_ack_o           ( rd_ack_o         ),
    .rd_data_o          ( rd_data_o        ),
    .flush_req_i        ( flush_req_i      ),
    .flush_ack_o        ( flush_ack_o      ),
    .cacheable_i        ( cacheable        ),
    .store_rd_index_o   ( store_rd_index   ),
    .tag_entry_i        ( tag_rd           ),
    .line_data_i        ( line_rd          ),
    .store_wr_en_o      ( store_wr_en      ),
    .store_wr_index_o   ( store_wr_index   ),
    .tag_wr_o           ( tag_wr           ),
    .line_wr_o          ( line_wr          ),
    .refill_start_o     ( refill_start     ),
    .refill_addr_o      ( refill_addr      ),
    .refill_full_line_o ( refill_full_line ),
    .refill_done_i      ( refill_done      ),
    .refill_line_i      ( refill_line      )
  );

  rocache_line_store #(
    .payload_t ( rocache_types_pkg::tag_entry_t )
  ) u_tag_store (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .rd_index_i   ( store_rd_index ),
    .rd_payload_o ( tag_rd         ),
    .wr_en_i      ( store_wr_en    ),
    .wr_index_i   ( store_wr_index ),
    .wr_payload_i ( tag_wr         )
  );

  rocache_line_store #(
    .payload_t ( rocache_types_pkg::line_t )
  ) u_data_store (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .rd_index_i   ( store_rd_index ),
    .rd_payload_o ( line_rd        ),
    .wr_en_i      ( store_wr_en    ),
    .wr_index_i   ( store_wr_index ),
    .wr_payload_i ( line_wr        )
  );

  rocache_refill u_refill (
    .clk_i              ( clk_i            ),
    .rst_ni             ( rst_ni           ),
    .refill_start_i     ( refill_start     ),
    .refill_addr_i      ( refill_addr      ),
    .refill_full_line_i ( refill_full_line ),
    .refill_done_o      ( refill_done      ),
    .refill_line_o      ( refill_line      ),
    .mem_req_o          ( mem_req_o        ),
    .mem_addr_o         ( mem_addr_o       ),
    .mem_ack_i          ( mem_ack_i        ),
    .mem_data_i         ( mem_data_i       )
  );

endmodule

`default_nettype wire

// ==== logic/rocache_ctrl.sv ====
// Cache controller that sequences lookup, line refill, bypass fetch, response and flush
`timescale 1ns/1ps
`default_nettype none

module rocache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_req_i,
  input  rocache_types_pkg::addr_t      rd_addr_i,
  output logic                          rd_ack_o,
  output rocache_types_pkg::word_t      rd_data_o,
  input  logic                          flush_req_i,
  output logic                          flush_ack_o,
  input  logic                          cacheable_i,
  output rocache_types_pkg::index_t     store_rd_index_o,
  input  rocache_types_pkg::tag_entry_t tag_entry_i,
  input  rocache_types_pkg::line_t      line_data_i,
  output logic                          store_wr_en_o,
  output rocache_types_pkg::index_t     store_wr_index_o,
  output rocache_types_pkg::tag_entry_t tag_wr_o,
  output rocache_types_pkg::line_t      line_wr_o,
  output logic                          refill_start_o,
  output rocache_types_pkg::addr_t      refill_addr_o,
  output logic                          refill_full_line_o,
  input  logic                          refill_done_i,
  input  rocache_types_pkg::line_t      refill_line_i
);

  localparam int unsigned INDEX_LSB = rocache_cfg_pkg::BYTE_OFF_W + rocache_cfg_pkg::WORD_OFF_W;

  rocache_types_pkg::ctrl_state_e          state_q;
  logic                                    rd_ack_q;
  logic                                    flush_ack_q;
  logic                                    resp_flush_q;
  rocache_types_pkg::index_t               flush_cnt_q;
  rocache_types_pkg::word_t                data_q;

  logic [rocache_cfg_pkg::TAG_W-1:0]       req_tag;
  rocache_types_pkg::index_t               req_index;
  logic [rocache_cfg_pkg::WORD_OFF_W-1:0]  req_word;
  logic                                    hit;
  logic                                    flush_last;

  // Address fields of the request stay stable while rd_req_i is high
  assign req_tag   = rd_addr_i[rocache_cfg_pkg::ADDR_W-1 -: rocache_cfg_pkg::TAG_W];
  assign req_index = rd_addr_i[INDEX_LSB +: rocache_cfg_pkg::INDEX_W];
  assign req_word  = rd_addr_i[rocache_cfg_pkg::BYTE_OFF_W +: rocache_cfg_pkg::WORD_OFF_W];

  assign hit = cacheable_i && tag_entry_i.valid && (tag_entry_i.tag == req_tag);
  assign flush_last = (flush_cnt_q ==
                       rocache_types_pkg::index_t'(rocache_cfg_pkg::LINE_COUNT - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= rocache_types_pkg::ST_IDLE;
      rd_ack_q     <= 1'b0;
      flush_ack_q  <= 1'b0;
      resp_flush_q <= 1'b0;
      flush_cnt_q  <= '0;
    end else begin
      case (state_q)
        rocache_types_pkg::ST_IDLE: begin
          // A pending read takes priority over a pending flush
          if (rd_req_i) begin
            state_q      <= rocache_types_pkg::ST_LOOKUP;
            resp_flush_q <= 1'b0;
          end else if (flush_req_i) begin
            state_q      <= rocache_types_pkg::ST_FLUSH;
            resp_flush_q <= 1'b1;
            flush_cnt_q  <= '0;
          end
        end
        rocache_types_pkg::ST_LOOKUP: begin
          if (hit) begin
            state_q <= rocache_types_pkg::ST_RESPOND;
          end else if (cacheable_i) begin
            state_q <= rocache_types_pkg::ST_REFILL;
          end else begin
            state_q <= rocache_types_pkg::ST_BYPASS;
          end
        end
        rocache_types_pkg::ST_REFILL, rocache_types_pkg::ST_BYPASS: begin
          if (refill_done_i) begin
            state_q <= rocache_types_pkg::ST_RESPOND;
          end
        end
        rocache_types_pkg::ST_RESPOND: begin
          // Ack follows the request and the falling request returns to idle
          if (resp_flush_q) begin
            flush_ack_q <= flush_req_i;
            if (!flush_req_i) begin
              state_q <= rocache_types_pkg::ST_IDLE;
            end
          end else begin
            rd_ack_q <= rd_req_i;
            if (!rd_req_i) begin
              state_q <= rocache_types_pkg::ST_IDLE;
            end
          end
        end
        rocache_types_pkg::ST_FLUSH: begin
          flush_cnt_q <= flush_cnt_q + 1'b1;
          if (flush_last) begin
            state_q <= rocache_types_pkg::ST_RESPOND;
          end
        end
        default: begin
          state_q <= rocache_types_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Response word comes from the hit line or the fetched line
  always_ff @(posedge clk_i) begin
    if (state_q == rocache_types_pkg::ST_LOOKUP && hit) begin
      data_q <= line_data_i[req_word];
    end else if (state_q == rocache_types_pkg::ST_REFILL && refill_done_i) begin
      data_q <= refill_line_i[req_word];
    end else if (state_q == rocache_types_pkg::ST_BYPASS && refill_done_i) begin
      data_q <= refill_line_i[0];
    end
  end

  assign rd_ack_o    = rd_ack_q;
  assign rd_data_o   = data_q;
  assign flush_ack_o = flush_ack_q;

  // Stores are read with the live request index
  assign store_rd_index_o = req_index;

  // Flush walks the tag store with invalid entries
  assign store_wr_en_o    = (state_q == rocache_types_pkg::ST_FLUSH) ||
                            (state_q == rocache_types_pkg::ST_REFILL && refill_done_i);
  assign store_wr_index_o = (state_q == rocache_types_pkg::ST_FLUSH) ? flush_cnt_q : req_index;
  assign tag_wr_o         = (state_q == rocache_types_pkg::ST_FLUSH) ?
                            '0 : rocache_types_pkg::tag_entry_t'{valid: 1'b1, tag: req_tag};
  assign line_wr_o        = refill_line_i;

  // Start pulse lasts one cycle because lookup always exits
  assign refill_start_o     = (state_q == rocache_types_pkg::ST_LOOKUP) && !hit;
  assign refill_addr_o      = rd_addr_i;
  assign refill_full_line_o = cacheable_i;

endmodule

`default_nettype wire

// ==== logic/rocache_refill.sv ====
// Refill unit that fetches one word or a full line from backing memory over req/ack
`timescale 1ns/1ps
`default_nettype none

module rocache_refill (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     refill_start_i,
  input  rocache_types_pkg::addr_t refill_addr_i,
  input  logic                     refill_full_line_i,
  output logic                     refill_done_o,
  output rocache_types_pkg::line_t refill_line_o,
  output logic                     mem_req_o,
  output rocache_types_pkg::addr_t mem_addr_o,
  input  logic                     mem_ack_i,
  input  rocache_types_pkg::word_t mem_data_i
);

  localparam int unsigned LINE_OFF_W = rocache_cfg_pkg::WORD_OFF_W + rocache_cfg_pkg::BYTE_OFF_W;

  logic                                     busy_q;
  logic                                     mem_req_q;
  logic                                     done_q;
  logic                                     full_line_q;
  logic [rocache_cfg_pkg::WORD_OFF_W-1:0]   word_cnt_q;
  rocache_types_pkg::addr_t                 base_addr_q;
  rocache_types_pkg::line_t                 line_q;
  logic                                     last_word;

  assign last_word = !full_line_q ||
                     (word_cnt_q == rocache_cfg_pkg::WORD_OFF_W'(rocache_cfg_pkg::LINE_WORDS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      mem_req_q   <= 1'b0;
      done_q      <= 1'b0;
      full_line_q <= 1'b0;
      word_cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (refill_start_i) begin
          busy_q      <= 1'b1;
          mem_req_q   <= 1'b1;
          full_line_q <= refill_full_line_i;
          word_cnt_q  <= '0;
        end
      end else if (mem_req_q) begin
        // First ack cycle ends the request phase
        if (mem_ack_i) begin
          mem_req_q <= 1'b0;
        end
      end else if (!mem_ack_i) begin
        // Ack has fallen so the word transfer is complete
        if (last_word) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          word_cnt_q <= word_cnt_q + 1'b1;
          mem_req_q  <= 1'b1;
        end
      end
    end
  end

  // Base address and captured words
  always_ff @(posedge clk_i) begin
    if (!busy_q && refill_start_i) begin
      if (refill_full_line_i) begin
        base_addr_q <= {refill_addr_i[rocache_cfg_pkg::ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
      end else begin
        base_addr_q <= {refill_addr_i[rocache_cfg_pkg::ADDR_W-1:rocache_cfg_pkg::BYTE_OFF_W],
                        {rocache_cfg_pkg::BYTE_OFF_W{1'b0}}};
      end
      line_q <= '0;
    end else if (busy_q && mem_req_q && mem_ack_i) begin
      line_q[word_cnt_q] <= mem_data_i;
    end
  end

  assign mem_req_o     = mem_req_q;
  assign mem_addr_o    = base_addr_q +
                         {{(rocache_cfg_pkg::ADDR_W - LINE_OFF_W){1'b0}},
                          word_cnt_q, {rocache_cfg_pkg::BYTE_OFF_W{1'b0}}};
  assign refill_done_o = done_q;
  assign refill_line_o = line_q;

endmodule

`default_nettype wire

// ==== logic/rocache_line_store.sv ====
// Line store holding a direct-mapped array with one write port and a registered read
`timescale 1ns/1ps
`default_nettype none

module rocache_line_store #(
  parameter type payload_t = logic
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rocache_types_pkg::index_t rd_index_i,
  output payload_t                  rd_payload_o,
  input  logic                      wr_en_i,
  input  rocache_types_pkg::index_t wr_index_i,
  input  payload_t                  wr_payload_i
);

  payload_t entries_q [rocache_cfg_pkg::LINE_COUNT];

  // Clearing every entry leaves all tags invalid after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rocache_cfg_pkg::LINE_COUNT; i++) begin
        entries_q[i] <= '0;
      end
      rd_payload_o <= '0;
    end else begin
      if (wr_en_i) begin
        entries_q[wr_index_i] <= wr_payload_i;
      end
      // Read returns the old entry when it collides with a write
      rd_payload_o <= entries_q[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/rocache_region_decode.sv ====
// Region decoder that flags a read address inside any cacheable range
`timescale 1ns/1ps
`default_nettype none

module rocache_region_decode (
  input  rocache_types_pkg::addr_t                                addr_i,
  input  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_start_i,
  input  rocache_types_pkg::addr_t [rocache_cfg_pkg::NR_RULES-1:0] range_end_i,
  output logic                                                    cacheable_o
);

  logic [rocache_cfg_pkg::NR_RULES-1:0] rule_match;

  // Start is inclusive and end is exclusive
  always_comb begin
    for (int i = 0; i < rocache_cfg_pkg::NR_RULES; i++) begin
      rule_match[i] = (addr_i >= range_start_i[i]) && (addr_i < range_end_i[i]);
    end
  end

  // No match means the read bypasses the cache
  assign cacheable_o = |rule_match;

endmodule

`default_nettype wire

// ==== logic/rocache_types_pkg.sv ====
// Read-only cache types for addresses, words, lines, tag entries and controller states
`default_nettype none

package rocache_types_pkg;

  typedef logic [rocache_cfg_pkg::ADDR_W-1:0] addr_t;
  typedef logic [rocache_cfg_pkg::WORD_W-1:0] word_t;

  // Word 0 sits at the lowest address of the line
  typedef word_t [rocache_cfg_pkg::LINE_WORDS-1:0] line_t;

  typedef logic [rocache_cfg_pkg::INDEX_W-1:0] index_t;

  typedef struct packed {
    logic                             valid;
    logic [rocache_cfg_pkg::TAG_W-1:0] tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_LOOKUP  = 3'd1,
    ST_REFILL  = 3'd2,
    ST_BYPASS  = 3'd3,
    ST_RESPOND = 3'd4,
    ST_FLUSH   = 3'd5
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/rocache_cfg_pkg.sv ====
// Read-only cache configuration with address, word and line geometry constants
`default_nettype none

package rocache_cfg_pkg;

  // Byte address and data word widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned WORD_W = 32;

  // Byte offset inside one word
  localparam int unsigned BYTE_OFF_W = 2;

  // Line geometry
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned WORD_OFF_W = 2;

  // Direct-mapped array of lines
  localparam int unsigned LINE_COUNT = 16;
  localparam int unsigned INDEX_W = 4;

  // Tag is whatever remains above index and offsets
  localparam int unsigned TAG_W = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  // Number of programmable cacheable address ranges
  localparam int unsigned NR_RULES = 2;

endpackage

`default_nettype wire
